// File: src/biriq_csr_settings.svh
`ifndef BIRIQ_CSR_SETTINGS_SVH
`define BIRIQ_CSR_SETTINGS_SVH

// machine trap setup and handling
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// counters and machine information
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_MHARTID   12'hF14

`define MTVEC_RESET   32'h0000_0100
`define HARTID        32'd0

`define MIE_BIT       3
`define MPIE_BIT      7
`define MSIP_BIT      3   // same positions in mie and mip
`define MTIP_BIT      7
`define MEIP_BIT      11

`endif

// File: src/biriq_csr_pkg.sv
package biriq_csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [29:0] epc_t;     // word address, low two bits dropped
    typedef logic [3:0]  cause_t;

    // bit 0 software, bit 1 timer, bit 2 external
    typedef logic [2:0]  irq_vec_t;

    typedef enum logic [1:0] {
        CSR_RD = 2'b00,
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        ACC_IDLE  = 2'b00,
        ACC_READ  = 2'b01,
        ACC_WRITE = 2'b10
    } access_state_e;

    // one access as presented on the request channel
    typedef struct packed {
        csr_addr_t addr;
        csr_op_e   op;
        xlen_t     wdata;
        logic      wr_en;
    } csr_req_t;

    typedef struct packed {
        logic      strobe;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wb_t;

    // at most one of exception, interrupt and mret is set
    typedef struct packed {
        logic   exception;
        logic   interrupt;
        logic   mret;
        epc_t   epc;
        xlen_t  mtval;
        cause_t mcause;
    } trap_req_t;

endpackage

// File: src/csr_access_fsm.sv
`timescale 1ns/1ps

module csr_access_fsm (
    input  wire logic                     cpu_clock_i,
    input  wire logic                     rst_n_i,
    input  wire logic                     csr_valid_i,
    input  wire biriq_csr_pkg::csr_req_t  csr_req_i,
    input  wire biriq_csr_pkg::xlen_t     trap_rd_data_i,
    input  wire logic                     trap_hit_i,
    input  wire logic                     trap_read_only_i,
    input  wire biriq_csr_pkg::xlen_t     cnt_rd_data_i,
    input  wire logic                     cnt_hit_i,
    output biriq_csr_pkg::csr_addr_t      rd_addr_o,
    output biriq_csr_pkg::csr_wb_t        wb_o,
    output logic                          csr_done_o,
    output logic                          csr_excp_o,
    output biriq_csr_pkg::xlen_t          csr_rdata_o
);
    import biriq_csr_pkg::*;

    access_state_e state_q;
    csr_req_t      req_q;
    xlen_t         old_q;
    logic          excp_q;
    xlen_t         sel_data;
    logic          sel_hit;
    logic          sel_excp;
    xlen_t         new_data;

    // both data modules decode the captured address at the same time
    assign rd_addr_o = req_q.addr;
    assign sel_hit   = trap_hit_i | cnt_hit_i;
    assign sel_data  = trap_hit_i ? trap_rd_data_i : cnt_rd_data_i;
    assign sel_excp  = !sel_hit || (req_q.wr_en && trap_read_only_i);

    always_comb begin
        case (req_q.op)
            CSR_RS:  new_data = old_q | req_q.wdata;
            CSR_RC:  new_data = old_q & ~req_q.wdata;
            default: new_data = req_q.wdata;
        endcase
    end

    assign wb_o.strobe = (state_q == ACC_WRITE) && req_q.wr_en && !excp_q
                         && (req_q.op != CSR_RD);
    assign wb_o.addr   = req_q.addr;
    assign wb_o.data   = new_data;
    assign csr_rdata_o = old_q;   // old value stays visible until the next access

    // the response is high for the one cycle spent in ACC_WRITE
    assign csr_done_o = (state_q == ACC_WRITE) && !excp_q;
    assign csr_excp_o = (state_q == ACC_WRITE) && excp_q;

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ACC_IDLE;
            excp_q  <= 1'b0;
        end else begin
            case (state_q)
                ACC_IDLE: begin
                    if (csr_valid_i) begin
                        state_q <= ACC_READ;
                    end
                end
                ACC_READ: begin
                    excp_q  <= sel_excp;
                    state_q <= ACC_WRITE;
                end
                ACC_WRITE: begin
                    state_q <= ACC_IDLE;
                end
                default: begin
                    state_q <= ACC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (state_q == ACC_IDLE && csr_valid_i) begin
            req_q <= csr_req_i;
        end
        if (state_q == ACC_READ) begin
            old_q <= sel_data;
        end
    end

endmodule

// File: src/csr_counters.sv
`timescale 1ns/1ps
`include "biriq_csr_settings.svh"

module csr_counters (
    input  wire logic                      cpu_clock_i,
    input  wire logic                      rst_n_i,
    input  wire biriq_csr_pkg::csr_addr_t  rd_addr_i,
    input  wire biriq_csr_pkg::csr_wb_t    wb_i,
    input  wire logic                      commit0_i,
    input  wire logic                      commit1_i,
    output biriq_csr_pkg::xlen_t           rd_data_o,
    output logic                           hit_o
);

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;
    logic [1:0]  retire_cnt;
    logic        wr_cyc_lo;
    logic        wr_cyc_hi;
    logic        wr_ret_lo;
    logic        wr_ret_hi;

    assign wr_cyc_lo  = wb_i.strobe && (wb_i.addr == `CSR_MCYCLE);
    assign wr_cyc_hi  = wb_i.strobe && (wb_i.addr == `CSR_MCYCLEH);
    assign wr_ret_lo  = wb_i.strobe && (wb_i.addr == `CSR_MINSTRET);
    assign wr_ret_hi  = wb_i.strobe && (wb_i.addr == `CSR_MINSTRETH);
    assign retire_cnt = {1'b0, commit0_i} + {1'b0, commit1_i};   // two commit slots per cycle

    // a written half loads as is and the count skips that cycle
    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mcycle_q <= '0;
        end else if (wr_cyc_lo) begin
            mcycle_q[31:0] <= wb_i.data;
        end else if (wr_cyc_hi) begin
            mcycle_q[63:32] <= wb_i.data;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            minstret_q <= '0;
        end else if (wr_ret_lo) begin
            minstret_q[31:0] <= wb_i.data;
        end else if (wr_ret_hi) begin
            minstret_q[63:32] <= wb_i.data;
        end else begin
            minstret_q <= minstret_q + {62'd0, retire_cnt};
        end
    end

    always_comb begin
        hit_o = 1'b1;
        case (rd_addr_i)
            `CSR_MCYCLE:    rd_data_o = mcycle_q[31:0];
            `CSR_MCYCLEH:   rd_data_o = mcycle_q[63:32];
            `CSR_MINSTRET:  rd_data_o = minstret_q[31:0];
            `CSR_MINSTRETH: rd_data_o = minstret_q[63:32];
            default: begin
                hit_o     = 1'b0;
                rd_data_o = '0;
            end
        endcase
    end

endmodule

// File: src/csr_trap_regs.sv
`timescale 1ns/1ps
`include "biriq_csr_settings.svh"

module csr_trap_regs (
    input  wire logic                      cpu_clock_i,
    input  wire logic                      rst_n_i,
    input  wire biriq_csr_pkg::csr_addr_t  rd_addr_i,
    input  wire biriq_csr_pkg::csr_wb_t    wb_i,
    input  wire biriq_csr_pkg::trap_req_t  trap_i,
    input  wire biriq_csr_pkg::irq_vec_t   ext_int_i,
    output biriq_csr_pkg::xlen_t           rd_data_o,
    output logic                           hit_o,
    output logic                           read_only_o,
    output biriq_csr_pkg::irq_vec_t        mip_o,
    output logic                           mie_o,
    output biriq_csr_pkg::epc_t            mepc_o,
    output biriq_csr_pkg::xlen_t           mtvec_o
);
    import biriq_csr_pkg::*;

    logic     mstatus_mie_q;
    logic     mstatus_mpie_q;
    irq_vec_t mie_q;
    irq_vec_t irq_q;
    xlen_t    mtvec_q;
    xlen_t    mscratch_q;
    epc_t     mepc_q;
    logic     mcause_int_q;
    cause_t   mcause_code_q;
    xlen_t    mtval_q;
    logic     trap_enter;
    xlen_t    mstatus_rd;
    xlen_t    mie_rd;
    xlen_t    mip_rd;

    assign trap_enter = trap_i.exception | trap_i.interrupt;

    // only MIE and MPIE are implemented in mstatus
    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end else if (trap_enter) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (trap_i.mret) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (wb_i.strobe && wb_i.addr == `CSR_MSTATUS) begin
            mstatus_mie_q  <= wb_i.data[`MIE_BIT];
            mstatus_mpie_q <= wb_i.data[`MPIE_BIT];
        end
    end

    // trap entry owns mepc, mcause and mtval for that cycle
    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mepc_q        <= '0;
            mcause_int_q  <= 1'b0;
            mcause_code_q <= '0;
            mtval_q       <= '0;
        end else if (trap_enter) begin
            mepc_q        <= trap_i.epc;
            mcause_int_q  <= trap_i.interrupt;
            mcause_code_q <= trap_i.mcause;
            mtval_q       <= trap_i.interrupt ? '0 : trap_i.mtval;
        end else if (wb_i.strobe) begin
            if (wb_i.addr == `CSR_MEPC) begin
                mepc_q <= wb_i.data[31:2];
            end
            if (wb_i.addr == `CSR_MCAUSE) begin
                mcause_int_q  <= wb_i.data[31];
                mcause_code_q <= wb_i.data[3:0];
            end
            if (wb_i.addr == `CSR_MTVAL) begin
                mtval_q <= wb_i.data;
            end
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mie_q      <= '0;
            mtvec_q    <= `MTVEC_RESET;
            mscratch_q <= '0;
        end else if (wb_i.strobe) begin
            if (wb_i.addr == `CSR_MIE) begin
                mie_q <= {wb_i.data[`MEIP_BIT], wb_i.data[`MTIP_BIT], wb_i.data[`MSIP_BIT]};
            end
            if (wb_i.addr == `CSR_MTVEC) begin
                mtvec_q <= wb_i.data;
            end
            if (wb_i.addr == `CSR_MSCRATCH) begin
                mscratch_q <= wb_i.data;
            end
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_q <= '0;
        end else begin
            irq_q <= ext_int_i;   // one register stage on the raw lines
        end
    end

    always_comb begin
        mstatus_rd                = '0;
        mstatus_rd[`MIE_BIT]      = mstatus_mie_q;
        mstatus_rd[`MPIE_BIT]     = mstatus_mpie_q;
        mie_rd                    = '0;
        mie_rd[`MSIP_BIT]         = mie_q[0];
        mie_rd[`MTIP_BIT]         = mie_q[1];
        mie_rd[`MEIP_BIT]         = mie_q[2];
        mip_rd                    = '0;
        mip_rd[`MSIP_BIT]         = irq_q[0];   // pending shows regardless of enable
        mip_rd[`MTIP_BIT]         = irq_q[1];
        mip_rd[`MEIP_BIT]         = irq_q[2];
    end

    always_comb begin
        hit_o       = 1'b1;
        read_only_o = 1'b0;
        case (rd_addr_i)
            `CSR_MSTATUS:  rd_data_o = mstatus_rd;
            `CSR_MIE:      rd_data_o = mie_rd;
            `CSR_MTVEC:    rd_data_o = mtvec_q;
            `CSR_MSCRATCH: rd_data_o = mscratch_q;
            `CSR_MEPC:     rd_data_o = {mepc_q, 2'b00};
            `CSR_MCAUSE:   rd_data_o = {mcause_int_q, 27'd0, mcause_code_q};
            `CSR_MTVAL:    rd_data_o = mtval_q;
            `CSR_MIP: begin
                rd_data_o   = mip_rd;
                read_only_o = 1'b1;
            end
            `CSR_MHARTID: begin
                rd_data_o   = `HARTID;
                read_only_o = 1'b1;
            end
            default: begin
                rd_data_o = '0;
                hit_o     = 1'b0;
            end
        endcase
    end

    assign mip_o   = irq_q & mie_q;
    assign mie_o   = mstatus_mie_q;
    assign mepc_o  = mepc_q;
    assign mtvec_o = mtvec_q;

endmodule

// File: src/biriq_csr.sv
`timescale 1ns/1ps

module biriq_csr (
    input  wire logic                      cpu_clock_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      csr_valid_i,
    input  wire biriq_csr_pkg::csr_req_t   csr_req_i,
    input  wire biriq_csr_pkg::trap_req_t  trap_i,
    input  wire biriq_csr_pkg::irq_vec_t   ext_int_i,
    input  wire logic                      commit0_i,
    input  wire logic                      commit1_i,
    output logic                           csr_done_o,
    output logic                           csr_excp_o,
    output biriq_csr_pkg::xlen_t           csr_rdata_o,
    output biriq_csr_pkg::irq_vec_t        mip_o,
    output logic                           mie_o,
    output biriq_csr_pkg::epc_t            mepc_o,
    output biriq_csr_pkg::xlen_t           mtvec_o
);
    import biriq_csr_pkg::*;

    csr_addr_t rd_addr;
    csr_wb_t   wb;
    xlen_t     trap_rd_data;
    logic      trap_hit;
    logic      trap_read_only;
    xlen_t     cnt_rd_data;
    logic      cnt_hit;

    csr_access_fsm fsm0 (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .csr_valid_i      (csr_valid_i),
        .csr_req_i        (csr_req_i),
        .trap_rd_data_i   (trap_rd_data),
        .trap_hit_i       (trap_hit),
        .trap_read_only_i (trap_read_only),
        .cnt_rd_data_i    (cnt_rd_data),
        .cnt_hit_i        (cnt_hit),
        .rd_addr_o        (rd_addr),
        .wb_o             (wb),
        .csr_done_o       (csr_done_o),
        .csr_excp_o       (csr_excp_o),
        .csr_rdata_o      (csr_rdata_o)
    );

    csr_counters cnt0 (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_i   (rd_addr),
        .wb_i        (wb),
        .commit0_i   (commit0_i),
        .commit1_i   (commit1_i),
        .rd_data_o   (cnt_rd_data),
        .hit_o       (cnt_hit)
    );

    csr_trap_regs trap0 (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_i   (rd_addr),
        .wb_i        (wb),
        .trap_i      (trap_i),
        .ext_int_i   (ext_int_i),
        .rd_data_o   (trap_rd_data),
        .hit_o       (trap_hit),
        .read_only_o (trap_read_only),
        .mip_o       (mip_o),
        .mie_o       (mie_o),
        .mepc_o      (mepc_o),
        .mtvec_o     (mtvec_o)
    );

endmodule

// File: bench/biriq_csr_chk.sv
`timescale 1ns/1ps

module biriq_csr_chk (
    input logic cpu_clock_i,
    input logic rst_n_i,
    input logic csr_valid_i,
    input logic csr_done_i,
    input logic csr_excp_i
);

    logic [1:0] busy_q;   // follows the read and write-back states of the access FSM
    logic       taken;

    assign taken = csr_valid_i && (busy_q == 2'b00);

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 2'b00;
        end else begin
            busy_q <= {busy_q[0], taken};
        end
    end

    a_single_response: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        !(csr_done_i && csr_excp_i))
        else $error("done and exception are high in the same cycle");

    a_response_follows: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        taken |-> ##2 (csr_done_i || csr_excp_i))
        else $error("no done or exception two cycles after an accepted request");

    // a pulse without an accepted request two cycles earlier is spurious
    a_response_has_request: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        (csr_done_i || csr_excp_i) |-> $past(taken, 2))
        else $error("done or exception without an accepted request");

    a_quiet_in_reset: assert property (@(posedge cpu_clock_i)
        !rst_n_i |-> (!csr_done_i && !csr_excp_i))
        else $error("done or exception high during reset");

endmodule

bind biriq_csr biriq_csr_chk chk0 (
    .cpu_clock_i (cpu_clock_i),
    .rst_n_i     (rst_n_i),
    .csr_valid_i (csr_valid_i),
    .csr_done_i  (csr_done_o),
    .csr_excp_i  (csr_excp_o)
);

// File: bench/biriq_csr_tb.sv
`timescale 1ns/1ps
`include "biriq_csr_settings.svh"

module biriq_csr_tb;
    import biriq_csr_pkg::*;

    logic        cpu_clock_i;
    logic        rst_n_i;
    logic        csr_valid_i;
    csr_req_t    csr_req_i;
    trap_req_t   trap_i;
    irq_vec_t    ext_int_i;
    logic        commit0_i;
    logic        commit1_i;
    logic        csr_done_o;
    logic        csr_excp_o;
    xlen_t       csr_rdata_o;
    irq_vec_t    mip_o;
    logic        mie_o;
    epc_t        mepc_o;
    xlen_t       mtvec_o;

    logic [31:0] steps [0:63][0:6];
    int          nsteps = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 100000;
    int          i;
    logic [31:0] lfsr = 32'h7cbb_ce10;
    logic [31:0] ret_sum = '0;   // commits since minstret was last written
    logic        sh_mie = 1'b0;
    logic        sh_mpie = 1'b0;
    irq_vec_t    sh_en = '0;
    logic [31:0] sh_mtvec = `MTVEC_RESET;

    biriq_csr dut0 (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .csr_valid_i (csr_valid_i),
        .csr_req_i   (csr_req_i),
        .trap_i      (trap_i),
        .ext_int_i   (ext_int_i),
        .commit0_i   (commit0_i),
        .commit1_i   (commit1_i),
        .csr_done_o  (csr_done_o),
        .csr_excp_o  (csr_excp_o),
        .csr_rdata_o (csr_rdata_o),
        .mip_o       (mip_o),
        .mie_o       (mie_o),
        .mepc_o      (mepc_o),
        .mtvec_o     (mtvec_o)
    );

    initial begin
        cpu_clock_i = 1'b0;
        forever #10 cpu_clock_i = ~cpu_clock_i;
    end

    always @(posedge cpu_clock_i) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the test steps did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] new_value(input logic [1:0] op, input logic [31:0] old,
                                              input logic [31:0] wdata);
        case (op)
            2'd1:    return wdata;
            2'd2:    return old | wdata;
            2'd3:    return old & ~wdata;
            default: return old;
        endcase
    endfunction

    function automatic int step_length(input logic [31:0] kind, input logic [31:0] arg);
        case (kind)
            0, 6:    return 6;
            5:       return arg + 2;
            7:       return arg + 10;
            default: return 3;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_steps();
        int          fd;
        int          total;
        string       line;
        fd = $fopen("bench/biriq_csr_testdata.txt", "r");
        total = 0;
        if (fd == 0) begin
            errors++;
            $display("cannot open the test data file bench/biriq_csr_testdata.txt");
        end else begin
            while (!$feof(fd) && nsteps < 64) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h", steps[nsteps][0],
                                steps[nsteps][1], steps[nsteps][2], steps[nsteps][3],
                                steps[nsteps][4], steps[nsteps][5], steps[nsteps][6]) == 7) begin
                        total += step_length(steps[nsteps][0], steps[nsteps][1]);
                        nsteps++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = 4 * total + 16 + 4;
    endtask

    // the shadow registers follow every completed write
    task automatic apply_write(input logic [11:0] addr, input logic [31:0] v);
        if (addr == `CSR_MSTATUS) begin
            sh_mie  = v[`MIE_BIT];
            sh_mpie = v[`MPIE_BIT];
        end
        if (addr == `CSR_MIE) sh_en = {v[`MEIP_BIT], v[`MTIP_BIT], v[`MSIP_BIT]};
        if (addr == `CSR_MTVEC) sh_mtvec = v;
        if (addr == `CSR_MINSTRET) ret_sum = v;
    endtask

    task automatic access_csr(input logic [11:0] addr, input logic [1:0] op, input logic wr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic excp, output int waited);
        logic seen;
        seen = 1'b0;
        excp = 1'b0;
        rdata = '0;
        waited = 0;
        @(posedge cpu_clock_i);
        csr_valid_i       <= 1'b1;
        csr_req_i.addr    <= addr;
        csr_req_i.op      <= csr_op_e'(op);
        csr_req_i.wdata   <= wdata;
        csr_req_i.wr_en   <= wr;
        @(posedge cpu_clock_i);
        csr_valid_i <= 1'b0;
        while (!seen && waited < 8) begin
            @(negedge cpu_clock_i);
            waited++;
            if (csr_done_o || csr_excp_o) begin
                seen  = 1'b1;
                excp  = csr_excp_o;
                rdata = csr_rdata_o;
            end
        end
        if (!seen) begin
            errors++;
            $display("%0t: no done or exception pulse for the access to CSR %h", $time, addr);
        end else if (!excp && wr && op != 2'd0) begin
            apply_write(addr, new_value(op, rdata, wdata));
        end
    endtask

    task automatic pulse_trap(input logic [1:0] kind, input logic [31:0] epc,
                              input logic [3:0] cause, input logic [31:0] tval);
        @(posedge cpu_clock_i);
        trap_i           <= '0;
        trap_i.exception <= (kind == 2'd1);
        trap_i.interrupt <= (kind == 2'd2);
        trap_i.mret      <= (kind == 2'd3);
        trap_i.epc       <= epc[31:2];
        trap_i.mtval     <= tval;
        trap_i.mcause    <= cause;
        @(posedge cpu_clock_i);
        trap_i <= '0;
        if (kind == 2'd3) begin
            sh_mie  = sh_mpie;
            sh_mpie = 1'b1;
        end else begin
            sh_mpie = sh_mie;
            sh_mie  = 1'b0;
        end
        @(negedge cpu_clock_i);
        if (kind != 2'd3) compare("mepc_o", {mepc_o, 2'b00}, {epc[31:2], 2'b00});
        compare("mie_o", mie_o, sh_mie);
    endtask

    task automatic run_step(input int idx);
        logic [31:0] a;
        logic [31:0] rdata;
        logic [31:0] rdata2;
        logic        excp;
        logic        c0;
        logic        c1;
        int          waited;
        a = steps[idx][1];
        case (steps[idx][0])
            0: begin
                access_csr(a[11:0], steps[idx][2][1:0], steps[idx][3][0], steps[idx][4],
                           rdata, excp, waited);
                compare("csr_excp_o", excp, steps[idx][6]);
                if (!excp && !steps[idx][6][0]) compare("csr_rdata_o", rdata, steps[idx][5]);
            end
            1, 2, 3: pulse_trap(steps[idx][0][1:0], a, steps[idx][2][3:0], steps[idx][3]);
            4: begin
                @(posedge cpu_clock_i);
                ext_int_i <= a[2:0];
                @(posedge cpu_clock_i);   // lines pass one register stage
                @(negedge cpu_clock_i);
                compare("mip_o", mip_o, a[2:0] & sh_en);
            end
            5: begin
                repeat (a) begin
                    @(posedge cpu_clock_i);
                    lfsr = lfsr_next(lfsr);
                    c0 = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    c1 = lfsr[0];
                    commit0_i <= c0;
                    commit1_i <= c1;
                    ret_sum = ret_sum + c0 + c1;
                end
                @(posedge cpu_clock_i);
                commit0_i <= 1'b0;
                commit1_i <= 1'b0;
            end
            6: begin
                access_csr(`CSR_MINSTRET, 2'd0, 1'b0, '0, rdata, excp, waited);
                compare("minstret", rdata, ret_sum);
            end
            7: begin
                access_csr(`CSR_MCYCLE, 2'd0, 1'b0, '0, rdata, excp, waited);
                repeat (a - waited - 1) @(posedge cpu_clock_i);
                access_csr(`CSR_MCYCLE, 2'd0, 1'b0, '0, rdata2, excp, waited);
                compare("mcycle delta", rdata2 - rdata, a);
            end
            default: begin
                errors++;
                $display("unknown step kind %0h in test data step %0d", steps[idx][0], idx);
            end
        endcase
    endtask

    initial begin
        rst_n_i     = 1'b0;
        csr_valid_i = 1'b0;
        csr_req_i   = '0;
        trap_i      = '0;
        ext_int_i   = '0;
        commit0_i   = 1'b0;
        commit1_i   = 1'b0;
        read_steps();
        repeat (16) @(posedge cpu_clock_i);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge cpu_clock_i);
        @(negedge cpu_clock_i);
        compare("mtvec_o", mtvec_o, sh_mtvec);
        for (i = 0; i < nsteps; i++) begin
            run_step(i);
        end
        repeat (4) @(posedge cpu_clock_i);
        @(negedge cpu_clock_i);
        compare("mtvec_o", mtvec_o, sh_mtvec);
        $display("%0d steps, %0d checks, %0d errors", nsteps, checks, errors);
        if (errors == 0 && nsteps > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: biriq_csr.f
+incdir+src
src/biriq_csr_pkg.sv
src/csr_access_fsm.sv
src/csr_counters.sv
src/csr_trap_regs.sv
src/biriq_csr.sv
bench/biriq_csr_chk.sv
bench/biriq_csr_tb.sv

// File: Bender.yml
package:
  name: biriq_csr

sources:
  - include_dirs:
      - src
    files:
      - src/biriq_csr_pkg.sv
      - src/csr_access_fsm.sv
      - src/csr_counters.sv
      - src/csr_trap_regs.sv
      - src/biriq_csr.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/biriq_csr_chk.sv
      - bench/biriq_csr_tb.sv

// File: bench/biriq_csr_testdata.txt
# kind 0 access: addr op wr_en wdata exp_rdata exp_excp | 1 exception: epc cause mtval
# 2 interrupt: epc cause | 3 mret | 4 irq: lines | 5 burst: cycles | 6 minstret | 7 mcycle: gap
0 305 0 0 0 00000100 0
0 F14 0 0 0 00000000 0
0 340 1 1 A5A50F0F 00000000 0
0 340 2 1 00F0F000 A5A50F0F 0
0 340 3 1 0000FF00 A5F5FF0F 0
0 340 0 0 0 A5F5000F 0
0 304 1 1 00000808 00000000 0
0 304 2 1 00000080 00000808 0
0 304 3 1 00000800 00000888 0
0 304 0 0 0 00000088 0
0 344 1 1 FFFFFFFF 0 1
0 F14 2 1 00000001 0 1
0 123 0 0 0 0 1
0 344 0 0 0 00000000 0
0 F14 0 0 0 00000000 0
0 300 2 1 00000008 00000000 0
1 00001234 2 DEADBEEF 0 0 0
0 342 0 0 0 00000002 0
0 343 0 0 0 DEADBEEF 0
0 341 0 0 0 00001234 0
0 300 2 1 00000008 00000080 0
2 00002000 7 0 0 0 0
0 342 0 0 0 80000007 0
0 343 0 0 0 00000000 0
3 0 0 0 0 0 0
0 300 0 0 0 00000088 0
4 7 0 0 0 0 0
0 344 0 0 0 00000888 0
4 4 0 0 0 0 0
0 B02 1 1 00000000 00000000 0
5 20 0 0 0 0 0
6 0 0 0 0 0 0
7 10 0 0 0 0 0
